// File: verilog/fpExecPkg.sv
`default_nettype none

package fpExecPkg;

    // Widths of the values moving through the stage
    localparam int fpDataWidth = 32;
    localparam int fpFlagsWidth = 5;
    localparam int alPtrWidth = 5;
    localparam int physRegWidth = 6;

    typedef logic [fpDataWidth-1:0] fpData;
    typedef logic [fpFlagsWidth-1:0] fpFlags;
    typedef logic [alPtrWidth-1:0] alPtr;
    typedef logic [physRegWidth-1:0] physReg;

    // Invalid operation bit, same position as in RISC-V fflags
    localparam int fpFlagNv = 4;

    // Quiet NaN returned by FMIN/FMAX when both inputs are NaN
    localparam fpData canonicalNan = 32'h7FC00000;

    // Miscellaneous single-precision operations
    typedef enum logic [2:0] {
        opFsgnj  = 3'd0,
        opFsgnjn = 3'd1,
        opFsgnjx = 3'd2,
        opFmin   = 3'd3,
        opFmax   = 3'd4,
        opFeq    = 3'd5,
        opFlt    = 3'd6,
        opFle    = 3'd7
    } fpOpCode;

    // Selective flush check against the active-list window
    // The range starts at flushHead and stops just before flushTail, with wrap
    function automatic logic isFlushed(
        input logic flushValid,
        input logic flushAll,
        input alPtr flushHead,
        input alPtr flushTail,
        input alPtr ptr
    );
        logic inRange;
        if (flushHead <= flushTail) begin
            inRange = (ptr >= flushHead) && (ptr < flushTail);
        end else begin
            // Window wraps past the top of the pointer space
            inRange = (ptr >= flushHead) || (ptr < flushTail);
        end
        return flushValid && (flushAll || inRange);
    endfunction

endpackage

`default_nettype wire

// File: verilog/fpStageIf.sv
`timescale 1ns/100ps
`default_nettype none

// One op in flight between two stage modules
interface fpStageIf;
    import fpExecPkg::*;

    logic valid;
    logic regValid;
    fpOpCode opCode;
    fpExecPkg::alPtr alPtr;
    physReg dstReg;
    fpData result;
    fpFlags flags;

    modport src (
        output valid,
        output regValid,
        output opCode,
        output alPtr,
        output dstReg,
        output result,
        output flags
    );

    modport dst (
        input valid,
        input regValid,
        input opCode,
        input alPtr,
        input dstReg,
        input result,
        input flags
    );

endinterface

`default_nettype wire

// File: verilog/fpMiscUnit.sv
`timescale 1ns/100ps
`default_nettype none

module fpMiscUnit (
    input  fpExecPkg::fpOpCode opCode,
    input  fpExecPkg::fpData   a,
    input  fpExecPkg::fpData   b,
    output fpExecPkg::fpData   result,
    output fpExecPkg::fpFlags  flags
);
    import fpExecPkg::*;

    logic nanA;
    logic nanB;
    logic snanA;
    logic snanB;
    logic bothZero;
    logic minLt;
    logic cmpLt;
    logic cmpEq;
    logic nv;

    // Operand classification
    assign nanA = (&a[30:23]) && (|a[22:0]);
    assign nanB = (&b[30:23]) && (|b[22:0]);
    // Signaling NaN has the quiet bit clear
    assign snanA = nanA && !a[22];
    assign snanB = nanB && !b[22];
    assign bothZero = (a[30:0] == '0) && (b[30:0] == '0);

    // Ordering for min/max, with -0 below +0
    always_comb begin
        if (a[31] != b[31]) begin
            minLt = a[31];
        end else if (!a[31]) begin
            minLt = a[30:0] < b[30:0];
        end else begin
            minLt = a[30:0] > b[30:0];
        end
    end

    // IEEE compare treats the two zeros as equal
    assign cmpLt = minLt && !bothZero;
    assign cmpEq = (a == b) || bothZero;

    always_comb begin
        result = '0;
        nv = 1'b0;
        unique case (opCode)
            opFsgnj:  result = {b[31], a[30:0]};
            opFsgnjn: result = {~b[31], a[30:0]};
            opFsgnjx: result = {a[31] ^ b[31], a[30:0]};
            opFmin, opFmax: begin
                nv = snanA || snanB;
                if (nanA && nanB) begin
                    result = canonicalNan;
                end else if (nanA) begin
                    result = b;
                end else if (nanB) begin
                    result = a;
                end else if ((opCode == opFmin) == minLt) begin
                    result = a;
                end else begin
                    result = b;
                end
            end
            opFeq: begin
                nv = snanA || snanB;
                result = {31'd0, !(nanA || nanB) && cmpEq};
            end
            opFlt: begin
                // Any NaN is invalid for the ordered compares
                nv = nanA || nanB;
                result = {31'd0, !(nanA || nanB) && cmpLt};
            end
            opFle: begin
                nv = nanA || nanB;
                result = {31'd0, !(nanA || nanB) && (cmpLt || cmpEq)};
            end
            default: result = '0;
        endcase
    end

    always_comb begin
        flags = '0;
        flags[fpFlagNv] = nv;
    end

endmodule

`default_nettype wire

// File: verilog/fpOperandStage.sv
`timescale 1ns/100ps
`default_nettype none

module fpOperandStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  logic                flushValid,
    input  logic                flushAll,
    input  fpExecPkg::alPtr     flushHead,
    input  fpExecPkg::alPtr     flushTail,
    input  logic                inValid,
    input  fpExecPkg::fpOpCode  inOpCode,
    input  fpExecPkg::alPtr     inAlPtr,
    input  fpExecPkg::physReg   inDst,
    input  fpExecPkg::fpData    regA,
    input  fpExecPkg::fpData    regB,
    input  logic                regReadyA,
    input  logic                regReadyB,
    input  logic                bypSelA,
    input  logic                bypSelB,
    input  fpExecPkg::fpData    bypA,
    input  fpExecPkg::fpData    bypB,
    input  logic                bypReadyA,
    input  logic                bypReadyB,
    fpStageIf.src               cap
);
    import fpExecPkg::*;

    // Capture register at the register-read boundary
    logic capValid;
    fpOpCode capOpCode;
    alPtr capAlPtr;
    physReg capDst;
    fpData capRegA;
    fpData capRegB;
    fpData capBypA;
    fpData capBypB;
    logic capRegReadyA;
    logic capRegReadyB;
    logic capBypSelA;
    logic capBypSelB;
    logic capBypReadyA;
    logic capBypReadyB;

    fpData opA;
    fpData opB;
    logic readyA;
    logic readyB;
    fpData miscResult;
    fpFlags miscFlags;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            capValid <= 1'b0;
        end else if (!stall) begin
            capValid <= inValid;
        end
    end

    // Payload holds while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            capOpCode <= inOpCode;
            capAlPtr <= inAlPtr;
            capDst <= inDst;
            capRegA <= regA;
            capRegB <= regB;
            capBypA <= bypA;
            capBypB <= bypB;
            capRegReadyA <= regReadyA;
            capRegReadyB <= regReadyB;
            capBypSelA <= bypSelA;
            capBypSelB <= bypSelB;
            capBypReadyA <= bypReadyA;
            capBypReadyB <= bypReadyB;
        end
    end

    // Operand pick between bypass network and register file
    assign opA = capBypSelA ? capBypA : capRegA;
    assign opB = capBypSelB ? capBypB : capRegB;
    assign readyA = capBypSelA ? capBypReadyA : capRegReadyA;
    assign readyB = capBypSelB ? capBypReadyB : capRegReadyB;

    fpMiscUnit fpMiscUnit_inst (
        .opCode (capOpCode),
        .a      (opA),
        .b      (opB),
        .result (miscResult),
        .flags  (miscFlags)
    );

    assign cap.valid = capValid &&
        !isFlushed(flushValid, flushAll, flushHead, flushTail, capAlPtr);
    // Not ready means the op goes back for replay
    assign cap.regValid = readyA && readyB;
    assign cap.opCode = capOpCode;
    assign cap.alPtr = capAlPtr;
    assign cap.dstReg = capDst;
    assign cap.result = miscResult;
    assign cap.flags = miscFlags;

    capOpKnown: assert property (@(posedge clk) disable iff (!rstN)
        capValid |-> !$isunknown(capOpCode));

endmodule

`default_nettype wire

// File: verilog/fpExecPipe.sv
`timescale 1ns/100ps
`default_nettype none

module fpExecPipe #(
    parameter int execDepth = 3
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             stall,
    input  logic             clear,
    input  logic             flushValid,
    input  logic             flushAll,
    input  fpExecPkg::alPtr  flushHead,
    input  fpExecPkg::alPtr  flushTail,
    fpStageIf.dst            cap,
    fpStageIf.src            head,
    fpStageIf.src            tail
);
    import fpExecPkg::*;

    localparam int nStg = execDepth - 1;

    // Delay line state
    logic stgValid [nStg];
    logic stgRegValid [nStg];
    fpOpCode stgOpCode [nStg];
    alPtr stgAlPtr [nStg];
    physReg stgDst [nStg];
    fpData stgResult [nStg];
    fpFlags stgFlags [nStg];

    // Valid bits as they enter each stage
    logic entValid [nStg];

    initial begin
        assert (execDepth >= 2 && execDepth <= 6)
            else $error("execDepth out of range");
    end

    always_comb begin
        entValid[0] = cap.valid &&
            !isFlushed(flushValid, flushAll, flushHead, flushTail, cap.alPtr);
        for (int j = 1; j < nStg; j++) begin
            entValid[j] = stgValid[j-1] &&
                !isFlushed(flushValid, flushAll, flushHead, flushTail, stgAlPtr[j-1]);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int j = 0; j < nStg; j++) begin
                stgValid[j] <= 1'b0;
                stgRegValid[j] <= 1'b0;
            end
        end else if (clear) begin
            for (int j = 0; j < nStg; j++) begin
                stgValid[j] <= 1'b0;
                stgRegValid[j] <= 1'b0;
            end
        end else if (!stall) begin
            stgValid[0] <= entValid[0];
            stgRegValid[0] <= cap.regValid;
            for (int j = 1; j < nStg; j++) begin
                stgValid[j] <= entValid[j];
                stgRegValid[j] <= stgRegValid[j-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stgOpCode[0] <= cap.opCode;
            stgAlPtr[0] <= cap.alPtr;
            stgDst[0] <= cap.dstReg;
            stgResult[0] <= cap.result;
            stgFlags[0] <= cap.flags;
            for (int j = 1; j < nStg; j++) begin
                stgOpCode[j] <= stgOpCode[j-1];
                stgAlPtr[j] <= stgAlPtr[j-1];
                stgDst[j] <= stgDst[j-1];
                stgResult[j] <= stgResult[j-1];
                stgFlags[j] <= stgFlags[j-1];
            end
        end
    end

    // First stage feeds replay, last stage feeds writeback
    assign head.valid = stgValid[0];
    assign head.regValid = stgRegValid[0];
    assign head.opCode = stgOpCode[0];
    assign head.alPtr = stgAlPtr[0];
    assign head.dstReg = stgDst[0];
    assign head.result = stgResult[0];
    assign head.flags = stgFlags[0];

    assign tail.valid = stgValid[nStg-1];
    assign tail.regValid = stgRegValid[nStg-1];
    assign tail.opCode = stgOpCode[nStg-1];
    assign tail.alPtr = stgAlPtr[nStg-1];
    assign tail.dstReg = stgDst[nStg-1];
    assign tail.result = stgResult[nStg-1];
    assign tail.flags = stgFlags[nStg-1];

    for (genvar j = 0; j < nStg; j++) begin : gValidChk
        stgValidKnown: assert property (@(posedge clk) disable iff (!rstN)
            !$isunknown(stgValid[j]));
    end

endmodule

`default_nettype wire

// File: verilog/fpResultStage.sv
`timescale 1ns/100ps
`default_nettype none

module fpResultStage (
    input  logic               stall,
    input  logic               clear,
    input  logic               flushValid,
    input  logic               flushAll,
    input  fpExecPkg::alPtr    flushHead,
    input  fpExecPkg::alPtr    flushTail,
    fpStageIf.dst              head,
    fpStageIf.dst              tail,
    output logic               replayValid,
    output fpExecPkg::alPtr    replayAlPtr,
    output logic               outValid,
    output logic               outDataValid,
    output fpExecPkg::physReg  outDst,
    output fpExecPkg::fpData   outData,
    output fpExecPkg::fpFlags  outFlags
);
    import fpExecPkg::*;

    logic headFlushed;
    logic tailFlushed;

    assign headFlushed = isFlushed(flushValid, flushAll, flushHead, flushTail, head.alPtr);
    assign tailFlushed = isFlushed(flushValid, flushAll, flushHead, flushTail, tail.alPtr);

    always_comb begin
        // Replay record one stage after capture
        replayValid = head.valid && !head.regValid && !headFlushed && !stall && !clear;
        replayAlPtr = head.alPtr;

        // Writeback record from the end of the delay line
        outValid = tail.valid && !tailFlushed && !stall && !clear;
        outDataValid = tail.regValid;
        outDst = tail.dstReg;
        outData = tail.result;
        outFlags = tail.flags;
    end

endmodule

`default_nettype wire

// File: verilog/fpExecStage.sv
`timescale 1ns/100ps
`default_nettype none

module fpExecStage #(
    parameter int execDepth = 3
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  logic                clear,
    input  logic                flushValid,
    input  logic                flushAll,
    input  fpExecPkg::alPtr     flushHead,
    input  fpExecPkg::alPtr     flushTail,
    input  logic                inValid,
    input  fpExecPkg::fpOpCode  inOpCode,
    input  fpExecPkg::alPtr     inAlPtr,
    input  fpExecPkg::physReg   inDst,
    input  fpExecPkg::fpData    regA,
    input  fpExecPkg::fpData    regB,
    input  logic                regReadyA,
    input  logic                regReadyB,
    input  logic                bypSelA,
    input  logic                bypSelB,
    input  fpExecPkg::fpData    bypA,
    input  fpExecPkg::fpData    bypB,
    input  logic                bypReadyA,
    input  logic                bypReadyB,
    output logic                replayValid,
    output fpExecPkg::alPtr     replayAlPtr,
    output logic                outValid,
    output logic                outDataValid,
    output fpExecPkg::physReg   outDst,
    output fpExecPkg::fpData    outData,
    output fpExecPkg::fpFlags   outFlags
);

    fpStageIf capToPipe ();
    // Index 0 is the first delay stage, index 1 the last
    fpStageIf pipeToRes [2] ();

    fpOperandStage fpOperandStage_inst (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .flushValid (flushValid),
        .flushAll   (flushAll),
        .flushHead  (flushHead),
        .flushTail  (flushTail),
        .inValid    (inValid),
        .inOpCode   (inOpCode),
        .inAlPtr    (inAlPtr),
        .inDst      (inDst),
        .regA       (regA),
        .regB       (regB),
        .regReadyA  (regReadyA),
        .regReadyB  (regReadyB),
        .bypSelA    (bypSelA),
        .bypSelB    (bypSelB),
        .bypA       (bypA),
        .bypB       (bypB),
        .bypReadyA  (bypReadyA),
        .bypReadyB  (bypReadyB),
        .cap        (capToPipe)
    );

    fpExecPipe #(
        .execDepth (execDepth)
    ) fpExecPipe_inst (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .clear      (clear),
        .flushValid (flushValid),
        .flushAll   (flushAll),
        .flushHead  (flushHead),
        .flushTail  (flushTail),
        .cap        (capToPipe),
        .head       (pipeToRes[0]),
        .tail       (pipeToRes[1])
    );

    fpResultStage fpResultStage_inst (
        .stall        (stall),
        .clear        (clear),
        .flushValid   (flushValid),
        .flushAll     (flushAll),
        .flushHead    (flushHead),
        .flushTail    (flushTail),
        .head         (pipeToRes[0]),
        .tail         (pipeToRes[1]),
        .replayValid  (replayValid),
        .replayAlPtr  (replayAlPtr),
        .outValid     (outValid),
        .outDataValid (outDataValid),
        .outDst       (outDst),
        .outData      (outData),
        .outFlags     (outFlags)
    );

endmodule

`default_nettype wire

// File: verification/fpExecStageTb.sv
`timescale 1ns/100ps
`default_nettype none

module fpExecStageTb;
    import fpExecPkg::*;

    localparam int execDepth = 3;
    localparam int nSpecial = 12;
    localparam int nRandomOps = 1200;
    localparam int totalOps = 8 * nSpecial * nSpecial + nRandomOps;
    localparam int timeoutCycles = totalOps * 20 + 200;

    // Expected record of one op between capture and writeback
    typedef struct {
        alPtr ptr;
        physReg dst;
        fpData data;
        fpFlags flags;
        logic dataValid;
        int age;
    } inflightRec;

    logic clk;
    logic rstN;
    logic stall;
    logic clear;
    logic flushValid;
    logic flushAll;
    alPtr flushHead;
    alPtr flushTail;
    logic inValid;
    fpOpCode inOpCode;
    alPtr inAlPtr;
    physReg inDst;
    fpData regA;
    fpData regB;
    logic regReadyA;
    logic regReadyB;
    logic bypSelA;
    logic bypSelB;
    fpData bypA;
    fpData bypB;
    logic bypReadyA;
    logic bypReadyB;
    logic replayValid;
    alPtr replayAlPtr;
    logic outValid;
    logic outDataValid;
    physReg outDst;
    fpData outData;
    fpFlags outFlags;

    integer seed;
    int errorCount;
    int checkCount;
    int stallLeft;
    alPtr nextPtr;
    inflightRec pending[$];

    fpExecStage #(
        .execDepth (execDepth)
    ) fpExecStage_inst (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .clear        (clear),
        .flushValid   (flushValid),
        .flushAll     (flushAll),
        .flushHead    (flushHead),
        .flushTail    (flushTail),
        .inValid      (inValid),
        .inOpCode     (inOpCode),
        .inAlPtr      (inAlPtr),
        .inDst        (inDst),
        .regA         (regA),
        .regB         (regB),
        .regReadyA    (regReadyA),
        .regReadyB    (regReadyB),
        .bypSelA      (bypSelA),
        .bypSelB      (bypSelB),
        .bypA         (bypA),
        .bypB         (bypB),
        .bypReadyA    (bypReadyA),
        .bypReadyB    (bypReadyB),
        .replayValid  (replayValid),
        .replayAlPtr  (replayAlPtr),
        .outValid     (outValid),
        .outDataValid (outDataValid),
        .outDst       (outDst),
        .outData      (outData),
        .outFlags     (outFlags)
    );

    always #5 clk = ~clk;

    function automatic int nextRand(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    // Signed zeros, infinities, quiet and signaling NaNs, a few normals
    function automatic fpData specialValue(input int idx);
        case (idx)
            0: return 32'h00000000;
            1: return 32'h80000000;
            2: return 32'h7F800000;
            3: return 32'hFF800000;
            4: return 32'h7FC00000;
            5: return 32'hFFC12345;
            6: return 32'h7F800001;
            7: return 32'hFFA00000;
            8: return 32'h3F800000;
            9: return 32'hBF800000;
            10: return 32'h00000001;
            default: return 32'h7F7FFFFF;
        endcase
    endfunction

    function automatic fpData pickOperand();
        if (nextRand(3) == 0) begin
            return specialValue(nextRand(nSpecial));
        end else begin
            return fpData'($random(seed));
        end
    endfunction

    // Circular window from head up to but not including tail
    function automatic logic ptrInRange(input alPtr ptr, input alPtr h, input alPtr t);
        alPtr off;
        alPtr span;
        off = ptr - h;
        span = t - h;
        return off < span;
    endfunction

    // Expected {flags, result} from the RISC-V rules for these ops
    function automatic logic [36:0] fpRef(input fpOpCode op, input fpData a, input fpData b);
        logic aNan;
        logic bNan;
        logic aSig;
        logic bSig;
        logic less;
        logic equal;
        int keyA;
        int keyB;
        fpData res;
        fpFlags fl;
        aNan = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
        bNan = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
        aSig = aNan && !a[22];
        bSig = bNan && !b[22];
        // Sign-magnitude mapped onto a signed line with both zeros at 0
        keyA = int'({1'b0, a[30:0]});
        keyB = int'({1'b0, b[30:0]});
        if (a[31]) keyA = -keyA;
        if (b[31]) keyB = -keyB;
        less = keyA < keyB;
        equal = keyA == keyB;
        res = '0;
        fl = '0;
        case (op)
            opFsgnj: res = {b[31], a[30:0]};
            opFsgnjn: res = {!b[31], a[30:0]};
            opFsgnjx: res = {a[31] ^ b[31], a[30:0]};
            opFmin, opFmax: begin
                fl[fpFlagNv] = aSig || bSig;
                if (aNan && bNan) begin
                    res = canonicalNan;
                end else if (aNan) begin
                    res = b;
                end else if (bNan) begin
                    res = a;
                end else if (equal) begin
                    // -0 counts below +0 here
                    if (op == opFmin) res = a[31] ? a : b;
                    else res = a[31] ? b : a;
                end else if (less == (op == opFmin)) begin
                    res = a;
                end else begin
                    res = b;
                end
            end
            opFeq: begin
                fl[fpFlagNv] = aSig || bSig;
                res[0] = !aNan && !bNan && equal;
            end
            opFlt: begin
                fl[fpFlagNv] = aNan || bNan;
                res[0] = !aNan && !bNan && less;
            end
            default: begin
                fl[fpFlagNv] = aNan || bNan;
                res[0] = !aNan && !bNan && (less || equal);
            end
        endcase
        return {fl, res};
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Model update and compare at mid-cycle where outputs are settled
    task automatic trackCycle();
        logic expOut;
        logic expReplay;
        alPtr expReplayPtr;
        inflightRec rec;
        logic [36:0] refVal;
        fpData opA;
        fpData opB;
        if (!stall && flushValid) begin
            for (int i = pending.size() - 1; i >= 0; i--) begin
                if (flushAll || ptrInRange(pending[i].ptr, flushHead, flushTail)) begin
                    pending.delete(i);
                end
            end
        end
        if (!stall && clear) pending.delete();

        expOut = !stall && (pending.size() > 0) && (pending[0].age == execDepth - 1);
        checkValue(32'(outValid), 32'(expOut), "outValid");
        if (expOut) begin
            rec = pending.pop_front();
            if (outValid) begin
                checkValue(32'(outDst), 32'(rec.dst), "outDst");
                checkValue(32'(outDataValid), 32'(rec.dataValid), "outDataValid");
                if (rec.dataValid) begin
                    checkValue(outData, rec.data, "outData");
                    checkValue(32'(outFlags), 32'(rec.flags), "outFlags");
                end
            end
        end

        expReplay = 1'b0;
        expReplayPtr = '0;
        for (int i = 0; i < pending.size(); i++) begin
            if (!stall && pending[i].age == 1 && !pending[i].dataValid) begin
                expReplay = 1'b1;
                expReplayPtr = pending[i].ptr;
            end
        end
        checkValue(32'(replayValid), 32'(expReplay), "replayValid");
        if (expReplay && replayValid) begin
            checkValue(32'(replayAlPtr), 32'(expReplayPtr), "replayAlPtr");
        end

        if (!stall) begin
            for (int i = 0; i < pending.size(); i++) begin
                pending[i].age = pending[i].age + 1;
            end
            if (inValid) begin
                opA = bypSelA ? bypA : regA;
                opB = bypSelB ? bypB : regB;
                refVal = fpRef(inOpCode, opA, opB);
                rec.ptr = inAlPtr;
                rec.dst = inDst;
                rec.data = refVal[31:0];
                rec.flags = refVal[36:32];
                rec.dataValid = (bypSelA ? bypReadyA : regReadyA) &&
                    (bypSelB ? bypReadyB : regReadyB);
                rec.age = 0;
                pending.push_back(rec);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstN) trackCycle();
    end

    task automatic setOperands(input fpData a, input fpData b, input logic ctrl);
        bypSelA = nextRand(2) == 1;
        bypSelB = nextRand(2) == 1;
        // Unselected source carries junk
        regA = bypSelA ? fpData'($random(seed)) : a;
        bypA = bypSelA ? a : fpData'($random(seed));
        regB = bypSelB ? fpData'($random(seed)) : b;
        bypB = bypSelB ? b : fpData'($random(seed));
        regReadyA = nextRand(2) == 1;
        regReadyB = nextRand(2) == 1;
        bypReadyA = nextRand(2) == 1;
        bypReadyB = nextRand(2) == 1;
        if (bypSelA) bypReadyA = !ctrl || nextRand(8) != 0;
        else regReadyA = !ctrl || nextRand(8) != 0;
        if (bypSelB) bypReadyB = !ctrl || nextRand(8) != 0;
        else regReadyB = !ctrl || nextRand(8) != 0;
    endtask

    // Stall bursts plus flush or clear on cycles without stall
    task automatic chooseControls(input logic ctrl);
        stall = 1'b0;
        clear = 1'b0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        if (ctrl) begin
            if (stallLeft > 0) begin
                stall = 1'b1;
                stallLeft--;
            end else if (nextRand(8) == 0) begin
                stall = 1'b1;
                stallLeft = nextRand(4);
            end
            if (!stall) begin
                flushValid = nextRand(16) == 0;
                flushAll = flushValid && (nextRand(4) == 0);
                flushHead = nextPtr - alPtr'(1 + nextRand(4));
                flushTail = flushHead + alPtr'(1 + nextRand(3));
                clear = nextRand(40) == 0;
            end
        end
    endtask

    task automatic presentOp(input fpOpCode op, input fpData a, input fpData b, input logic ctrl);
        logic taken;
        inValid = 1'b1;
        inOpCode = op;
        inAlPtr = nextPtr;
        inDst = physReg'(nextRand(64));
        setOperands(a, b, ctrl);
        taken = 1'b0;
        // Op is held until an edge without stall takes it
        while (!taken) begin
            chooseControls(ctrl);
            taken = !stall;
            @(posedge clk);
            #1;
        end
        inValid = 1'b0;
        nextPtr = nextPtr + 5'd1;
    endtask

    task automatic idleCycle();
        inValid = 1'b0;
        chooseControls(1'b1);
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed = 32'hafeb4bf8;
        clk = 1'b0;
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        inValid = 1'b0;
        inOpCode = opFsgnj;
        inAlPtr = '0;
        inDst = '0;
        regA = '0;
        regB = '0;
        regReadyA = 1'b0;
        regReadyB = 1'b0;
        bypSelA = 1'b0;
        bypSelB = 1'b0;
        bypA = '0;
        bypB = '0;
        bypReadyA = 1'b0;
        bypReadyB = 1'b0;
        errorCount = 0;
        checkCount = 0;
        stallLeft = 0;
        nextPtr = '0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Every op on every pair of special values back to back
        for (int op = 0; op < 8; op++) begin
            for (int ia = 0; ia < nSpecial; ia++) begin
                for (int ib = 0; ib < nSpecial; ib++) begin
                    presentOp(fpOpCode'(3'(op)), specialValue(ia), specialValue(ib), 1'b0);
                end
            end
        end

        // Random ops with stalls, flushes, clears and unready operands
        for (int n = 0; n < nRandomOps; n++) begin
            if (nextRand(5) == 0) idleCycle();
            presentOp(fpOpCode'(3'(nextRand(8))), pickOperand(), pickOperand(), 1'b1);
        end

        stall = 1'b0;
        clear = 1'b0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        while (pending.size() > 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
verilog/fpExecPkg.sv
verilog/fpStageIf.sv
verilog/fpMiscUnit.sv
verilog/fpOperandStage.sv
verilog/fpExecPipe.sv
verilog/fpResultStage.sv
verilog/fpExecStage.sv
verification/fpExecStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f files.f \
    --top-module fpExecStageTb \
    --Mdir build \
    -o fpExecStageSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./build/fpExecStageSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx ">>> PASS" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
